/* soc_event_domain.f */
+incdir+common
common/soc_event_pkg.sv
common/per_bus_if.sv
cluster_events/edge_rx.sv
cluster_events/event_dc_fifo.sv
source/apb_per_bridge.sv
source/soc_ctrl_regs.sv
source/soc_event_domain.sv
sim/tb_soc_event_domain.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_soc_event_domain
FLIST     := soc_event_domain.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif grep -q "sim passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_soc_event_domain.sv */
// ************************************************
// directed testbench for the soc event domain
// apb tasks, cluster-side ring model, watchdog
// ************************************************

`include "soc_event_defs.svh"

module tb_soc_event_domain;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH     = `SOC_EVT_FIFO_DEPTH;
  localparam int NUM_TESTS = 6;
  localparam int MAX_WAIT  = 20;

  logic                         s_soc_clk;
  logic                         s_soc_rstn;
  logic                         cluster_rstn;
  logic [`SOC_APB_AW-1:0]       paddr;
  logic [`SOC_DW-1:0]           pwdata;
  logic [`SOC_DW-1:0]           prdata;
  logic                         pwrite, psel, penable, pready, pslverr;
  logic                         cl_fetch_en, cl_irq, cl_rstn;
  logic [`SOC_DW-1:0]           boot_addr;
  soc_event_pkg::core_mask_t    dbg_req;
  logic [DEPTH-1:0]             write_token;
  logic [DEPTH-1:0]             read_pointer;
  logic [DEPTH*`SOC_EVNT_W-1:0] slot_bus;
  logic                         dma_evt, dma_irq, pf_evt;
  logic                         dma_evt_ack, dma_irq_ack, pf_evt_ack;

  logic [31:0]                  lfsr_q;
  int                           wr_idx;
  int                           rd_idx;
  soc_event_pkg::evt_data_t     pushed_q[$];

  soc_event_domain dut0 (
    .s_soc_clk               (s_soc_clk),
    .s_soc_rstn              (s_soc_rstn),
    .cluster_rstn_i          (cluster_rstn),
    .paddr_i                 (paddr),
    .pwdata_i                (pwdata),
    .pwrite_i                (pwrite),
    .psel_i                  (psel),
    .penable_i               (penable),
    .prdata_o                (prdata),
    .pready_o                (pready),
    .pslverr_o               (pslverr),
    .cluster_fetch_enable_o  (cl_fetch_en),
    .cluster_boot_addr_o     (boot_addr),
    .cluster_irq_o           (cl_irq),
    .cluster_rstn_o          (cl_rstn),
    .cluster_dbg_irq_valid_o (dbg_req),
    .cluster_events_wt_o     (write_token),
    .cluster_events_rp_i     (read_pointer),
    .cluster_events_da_o     (slot_bus),
    .dma_pe_evt_valid_i      (dma_evt),
    .dma_pe_irq_valid_i      (dma_irq),
    .pf_evt_valid_i          (pf_evt),
    .dma_pe_evt_ack_o        (dma_evt_ack),
    .dma_pe_irq_ack_o        (dma_irq_ack),
    .pf_evt_ack_o            (pf_evt_ack)
  );

  initial begin : clock_gen
    s_soc_clk = 1'b0;
    forever #10 s_soc_clk = ~s_soc_clk;
  end

  // whole run budget of 2 us per test
  initial begin : watchdog
    #(NUM_TESTS * 2000);
    $display("timeout: the run did not finish within its time budget");
    stop_on_error();
  end

  // ************************************************
  // error handling and compare tasks
  // ************************************************

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input logic [`SOC_DW-1:0] got, input logic [`SOC_DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ctrl(input soc_event_pkg::cl_ctrl_t got,
                            input soc_event_pkg::cl_ctrl_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_mask(input soc_event_pkg::core_mask_t got,
                            input soc_event_pkg::core_mask_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_evt(input soc_event_pkg::evt_data_t got,
                           input soc_event_pkg::evt_data_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_status(input soc_event_pkg::evt_status_t got,
                              input soc_event_pkg::evt_status_t exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // ************************************************
  // stimulus helpers
  // ************************************************

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [DEPTH-1:0] token_at(input int idx);
    logic [DEPTH-1:0] tok;
    tok = '0;
    tok[idx] = 1'b1;
    return tok;
  endfunction

  function automatic soc_event_pkg::evt_data_t slot_data(input int idx);
    return slot_bus[idx*`SOC_EVNT_W +: `SOC_EVNT_W];
  endfunction

  function automatic soc_event_pkg::cl_ctrl_t ctrl_pins();
    soc_event_pkg::cl_ctrl_t pins;
    pins.fetch_en = cl_fetch_en;
    pins.rstn     = cl_rstn;
    pins.irq      = cl_irq;
    return pins;
  endfunction

  task automatic to_drive_edge();
    @(posedge s_soc_clk);
    #2;
  endtask

  // setup cycle, then access until pready
  task automatic apb_access(input logic write, input logic [`SOC_APB_AW-1:0] addr,
                            input logic [`SOC_DW-1:0] wdata, output logic [`SOC_DW-1:0] rdata);
    int cycles;
    to_drive_edge();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    to_drive_edge();
    penable = 1'b1;
    cycles  = 0;
    do begin
      @(negedge s_soc_clk);
      cycles++;
    end while (!pready && cycles < MAX_WAIT);
    if (!pready) begin
      $display("timeout: APB access to %h never saw PREADY", addr);
      stop_on_error();
    end
    check_word(32'(cycles), 32'd2, "APB access phase cycles");
    check_word(32'(pslverr), 32'd0, "PSLVERR");
    rdata = prdata;
    to_drive_edge();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`SOC_APB_AW-1:0] addr, input logic [`SOC_DW-1:0] wdata);
    logic [`SOC_DW-1:0] unused;
    apb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input logic [`SOC_APB_AW-1:0] addr, output logic [`SOC_DW-1:0] rdata);
    apb_access(1'b0, addr, '0, rdata);
  endtask

  task automatic read_status(output soc_event_pkg::evt_status_t st);
    logic [`SOC_DW-1:0] rd;
    apb_read(`SOC_REG_EVT_STATUS, rd);
    check_word(rd & ~32'hF, 32'd0, "status upper bits");
    st = soc_event_pkg::evt_status_t'(rd[3:0]);
  endtask

  // ************************************************
  // cluster-side ring model
  // ************************************************

  // hold the cluster in reset, then release with fetch enabled
  task automatic release_cluster();
    apb_write(`SOC_REG_CL_CTRL, 32'h0);
    check_word(32'(write_token), 32'd1, "write token in cluster reset");
    read_pointer = token_at(0);
    wr_idx = 0;
    rd_idx = 0;
    pushed_q.delete();
    apb_write(`SOC_REG_CL_CTRL, 32'h6);
    check_word(32'(cl_rstn), 32'd1, "cluster reset released");
  endtask

  task automatic wait_push_ready();
    logic [`SOC_DW-1:0] rd;
    int tries;
    tries = 0;
    rd = '0;
    while (rd[0] !== 1'b1 && tries < MAX_WAIT) begin
      apb_read(`SOC_REG_EVT_PUSH, rd);
      tries++;
    end
    if (rd[0] !== 1'b1) begin
      $display("timeout: event FIFO never reported ready");
      stop_on_error();
    end
  endtask

  task automatic push_event(input logic [`SOC_DW-1:0] wdata);
    logic [DEPTH-1:0] tok_before;
    int waited;
    wait_push_ready();
    check_word(32'(write_token), 32'(token_at(wr_idx)), "write token before push");
    tok_before = write_token;
    apb_write(`SOC_REG_EVT_PUSH, wdata);
    waited = 0;
    while (write_token == tok_before && waited < MAX_WAIT) begin
      @(negedge s_soc_clk);
      waited++;
    end
    if (write_token == tok_before) begin
      $display("timeout: write token did not advance after a push");
      stop_on_error();
    end
    check_evt(slot_data(wr_idx), wdata[`SOC_EVNT_W-1:0], "event slot after push");
    pushed_q.push_back(wdata[`SOC_EVNT_W-1:0]);
    wr_idx = (wr_idx + 1) % DEPTH;
    check_word(32'(write_token), 32'(token_at(wr_idx)), "write token after push");
  endtask

  // cluster reads the oldest slot and moves its pointer on
  task automatic drain_one();
    soc_event_pkg::evt_data_t exp;
    exp = pushed_q.pop_front();
    check_evt(slot_data(rd_idx), exp, "cluster read of event slot");
    rd_idx = (rd_idx + 1) % DEPTH;
    to_drive_edge();
    read_pointer = token_at(rd_idx);
  endtask

  task automatic drive_event(input int which, input logic level);
    to_drive_edge();
    case (which)
      0: dma_evt = level;
      1: dma_irq = level;
      default: pf_evt = level;
    endcase
  endtask

  function automatic logic event_ack(input int which);
    case (which)
      0: return dma_evt_ack;
      1: return dma_irq_ack;
      default: return pf_evt_ack;
    endcase
  endfunction

  task automatic wait_ack(input int which, input logic level);
    int waited;
    waited = 0;
    while (event_ack(which) !== level && waited < MAX_WAIT) begin
      @(negedge s_soc_clk);
      waited++;
    end
    if (event_ack(which) !== level) begin
      $display("timeout: ack of event input %0d never reached %0b", which, level);
      stop_on_error();
    end
  endtask

  // ************************************************
  // directed tests
  // ************************************************

  task automatic reset_values();
    logic [`SOC_DW-1:0] rd;
    check_word(32'(pready), 32'd0, "PREADY after reset");
    check_ctrl(ctrl_pins(), '0, "cluster controls after reset");
    check_mask(dbg_req, '0, "debug requests after reset");
    check_word(32'(write_token), 32'd1, "write token after reset");
    apb_read(`SOC_REG_BOOT_ADDR, rd);
    check_word(rd, `SOC_BOOT_ADDR_RST, "boot address after reset");
    apb_read(`SOC_REG_CL_CTRL, rd);
    check_word(rd, 32'd0, "cluster control after reset");
    apb_read(`SOC_REG_DBG_REQ, rd);
    check_word(rd, 32'd0, "debug request after reset");
  endtask

  task automatic ctrl_regs_readback();
    logic [`SOC_DW-1:0] w;
    logic [`SOC_DW-1:0] rd;
    soc_event_pkg::cl_ctrl_t   exp_ctrl;
    soc_event_pkg::core_mask_t exp_mask;
    repeat (3) begin
      draw_bits(32, w);
      apb_write(`SOC_REG_BOOT_ADDR, w);
      apb_read(`SOC_REG_BOOT_ADDR, rd);
      check_word(rd, w, "boot address readback");
      check_word(boot_addr, w, "cluster boot address");
      draw_bits(32, w);
      exp_ctrl.fetch_en = w[2];
      exp_ctrl.rstn     = w[1];
      exp_ctrl.irq      = w[0];
      apb_write(`SOC_REG_CL_CTRL, w);
      apb_read(`SOC_REG_CL_CTRL, rd);
      check_word(rd, 32'(exp_ctrl), "cluster control readback");
      check_ctrl(ctrl_pins(), exp_ctrl, "cluster control pins");
      draw_bits(32, w);
      exp_mask = w[`SOC_NB_CORES-1:0];
      apb_write(`SOC_REG_DBG_REQ, w);
      apb_read(`SOC_REG_DBG_REQ, rd);
      check_word(rd, 32'(exp_mask), "debug request readback");
      check_mask(dbg_req, exp_mask, "cluster debug requests");
    end
  endtask

  // the second of two bursts wraps past the last slot
  task automatic event_ring_push();
    logic [`SOC_DW-1:0] w;
    soc_event_pkg::evt_status_t st;
    release_cluster();
    repeat (2) begin
      repeat (5) begin
        draw_bits(32, w);
        push_event(w);
      end
      while (pushed_q.size() > 0) begin
        drain_one();
      end
    end
    read_status(st);
    check_status(st, '0, "status after ring traffic");
  endtask

  task automatic ring_back_pressure();
    logic [`SOC_DW-1:0] w;
    soc_event_pkg::evt_status_t st;
    soc_event_pkg::evt_status_t exp;
    release_cluster();
    repeat (DEPTH - 1) begin
      draw_bits(32, w);
      push_event(w);
    end
    // this push finds the ring full and is dropped
    draw_bits(32, w);
    apb_write(`SOC_REG_EVT_PUSH, w);
    check_word(32'(write_token), 32'(token_at(wr_idx)), "write token on a full ring");
    exp = '0;
    exp.push_drop = 1'b1;
    read_status(st);
    check_status(st, exp, "status after push to a full ring");
    read_status(st);
    check_status(st, '0, "status after clearing read");
    drain_one();
    draw_bits(32, w);
    push_event(w);
    while (pushed_q.size() > 0) begin
      drain_one();
    end
    read_status(st);
    check_status(st, '0, "status after released push");
  endtask

  task automatic edge_event_status();
    soc_event_pkg::evt_status_t st;
    soc_event_pkg::evt_status_t exp;
    release_cluster();
    read_status(st);
    for (int which = 0; which < 3; which++) begin
      exp = '0;
      case (which)
        0: exp.dma_pe_evt = 1'b1;
        1: exp.dma_pe_irq = 1'b1;
        default: exp.pf_evt = 1'b1;
      endcase
      drive_event(which, 1'b1);
      wait_ack(which, 1'b1);
      read_status(st);
      check_status(st, exp, "sticky bit after cluster event");
      read_status(st);
      check_status(st, '0, "status cleared by its read");
      drive_event(which, 1'b0);
      wait_ack(which, 1'b0);
      read_status(st);
      check_status(st, '0, "status after falling event level");
    end
  endtask

  task automatic cluster_reset_drop();
    logic [`SOC_DW-1:0] w;
    logic [`SOC_DW-1:0] rd;
    soc_event_pkg::cl_ctrl_t    exp_ctrl;
    soc_event_pkg::evt_status_t st;
    soc_event_pkg::evt_status_t exp;
    // fetch enabled but cluster held in reset
    apb_write(`SOC_REG_CL_CTRL, 32'h4);
    exp_ctrl = '0;
    exp_ctrl.fetch_en = 1'b1;
    check_ctrl(ctrl_pins(), exp_ctrl, "cluster pins while held in reset");
    check_word(32'(write_token), 32'd1, "write token while held in reset");
    read_status(st);
    apb_read(`SOC_REG_EVT_PUSH, rd);
    check_word(rd, 32'd0, "FIFO ready while held in reset");
    draw_bits(32, w);
    apb_write(`SOC_REG_EVT_PUSH, w);
    check_word(32'(write_token), 32'd1, "write token after push in reset");
    exp = '0;
    exp.push_drop = 1'b1;
    read_status(st);
    check_status(st, exp, "status after push in reset");
  endtask

  initial begin : main
    s_soc_rstn   = 1'b0;
    cluster_rstn = 1'b1;
    paddr        = '0;
    pwdata       = '0;
    pwrite       = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    read_pointer = token_at(0);
    dma_evt      = 1'b0;
    dma_irq      = 1'b0;
    pf_evt       = 1'b0;
    lfsr_q       = 32'h2d5aa790;
    wr_idx       = 0;
    rd_idx       = 0;
    repeat (4) @(posedge s_soc_clk);
    #2 s_soc_rstn = 1'b1;
    reset_values();
    ctrl_regs_readback();
    event_ring_push();
    ring_back_pressure();
    edge_event_status();
    cluster_reset_drop();
    $display("sim passed");
    $finish;
  end

endmodule

/* source/soc_event_domain.sv */
// ************************************************
// soc side control path toward the cluster
// apb bridge, control regs, event fifo and rx
// ************************************************

`include "soc_event_defs.svh"

module soc_event_domain (
  input  logic                                       s_soc_clk,
  input  logic                                       s_soc_rstn,
  input  logic                                       cluster_rstn_i,
  input  logic [`SOC_APB_AW-1:0]                     paddr_i,
  input  logic [`SOC_DW-1:0]                         pwdata_i,
  input  logic                                       pwrite_i,
  input  logic                                       psel_i,
  input  logic                                       penable_i,
  output logic [`SOC_DW-1:0]                         prdata_o,
  output logic                                       pready_o,
  output logic                                       pslverr_o,
  output logic                                       cluster_fetch_enable_o,
  output logic [`SOC_DW-1:0]                         cluster_boot_addr_o,
  output logic                                       cluster_irq_o,
  output logic                                       cluster_rstn_o,
  output soc_event_pkg::core_mask_t                  cluster_dbg_irq_valid_o,
  output logic [`SOC_EVT_FIFO_DEPTH-1:0]             cluster_events_wt_o,
  input  logic [`SOC_EVT_FIFO_DEPTH-1:0]             cluster_events_rp_i,
  output logic [`SOC_EVT_FIFO_DEPTH*`SOC_EVNT_W-1:0] cluster_events_da_o,
  input  logic                                       dma_pe_evt_valid_i,
  input  logic                                       dma_pe_irq_valid_i,
  input  logic                                       pf_evt_valid_i,
  output logic                                       dma_pe_evt_ack_o,
  output logic                                       dma_pe_irq_ack_o,
  output logic                                       pf_evt_ack_o
);

  soc_event_pkg::cl_ctrl_t   s_cl_ctrl;
  soc_event_pkg::evt_data_t  s_evt_data;
  logic                      s_evt_valid, s_evt_ready;
  logic                      s_dma_pe_evt, s_dma_pe_irq, s_pf_evt;
  logic                      s_rstn_cluster;

  per_bus_if s_per_bus ();

  // cluster reset gated by the control register
  assign s_rstn_cluster         = cluster_rstn_i & s_cl_ctrl.rstn;
  assign cluster_rstn_o         = s_rstn_cluster;
  assign cluster_fetch_enable_o = s_cl_ctrl.fetch_en;
  assign cluster_irq_o          = s_cl_ctrl.irq;

  apb_per_bridge i_apb_per_bridge (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .pwrite_i   (pwrite_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .per        (s_per_bus.master)
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .per          (s_per_bus.slave),
    .evt_data_o   (s_evt_data),
    .evt_valid_o  (s_evt_valid),
    .evt_ready_i  (s_evt_ready),
    .dma_pe_evt_i (s_dma_pe_evt),
    .dma_pe_irq_i (s_dma_pe_irq),
    .pf_evt_i     (s_pf_evt),
    .cl_ctrl_o    (s_cl_ctrl),
    .boot_addr_o  (cluster_boot_addr_o),
    .dbg_req_o    (cluster_dbg_irq_valid_o)
  );

  // events toward the cluster
  event_dc_fifo i_event_dc_fifo (
    .s_soc_clk      (s_soc_clk),
    .rstn_i         (s_rstn_cluster),
    .data_i         (s_evt_data),
    .valid_i        (s_evt_valid),
    .ready_o        (s_evt_ready),
    .write_token_o  (cluster_events_wt_o),
    .read_pointer_i (cluster_events_rp_i),
    .data_async_o   (cluster_events_da_o)
  );

  // events from the cluster
  edge_rx i_edge_dma_pe_evt (
    .s_soc_clk (s_soc_clk),
    .rstn_i    (s_rstn_cluster),
    .valid_i   (dma_pe_evt_valid_i),
    .valid_o   (s_dma_pe_evt),
    .ack_o     (dma_pe_evt_ack_o)
  );

  edge_rx i_edge_dma_pe_irq (
    .s_soc_clk (s_soc_clk),
    .rstn_i    (s_rstn_cluster),
    .valid_i   (dma_pe_irq_valid_i),
    .valid_o   (s_dma_pe_irq),
    .ack_o     (dma_pe_irq_ack_o)
  );

  edge_rx i_edge_pf_evt (
    .s_soc_clk (s_soc_clk),
    .rstn_i    (s_rstn_cluster),
    .valid_i   (pf_evt_valid_i),
    .valid_o   (s_pf_evt),
    .ack_o     (pf_evt_ack_o)
  );

endmodule

/* source/soc_ctrl_regs.sv */
// ************************************************
// cluster control, debug request and event regs
// pushes events toward the cluster fifo
// ************************************************

`include "soc_event_defs.svh"

module soc_ctrl_regs (
  input  logic                        s_soc_clk,
  input  logic                        s_soc_rstn,
  per_bus_if.slave                    per,
  output soc_event_pkg::evt_data_t    evt_data_o,
  output logic                        evt_valid_o,
  input  logic                        evt_ready_i,
  input  logic                        dma_pe_evt_i,
  input  logic                        dma_pe_irq_i,
  input  logic                        pf_evt_i,
  output soc_event_pkg::cl_ctrl_t     cl_ctrl_o,
  output logic [`SOC_DW-1:0]          boot_addr_o,
  output soc_event_pkg::core_mask_t   dbg_req_o
);

  soc_event_pkg::reg_addr_e    reg_addr;
  soc_event_pkg::cl_ctrl_t     cl_ctrl_q;
  soc_event_pkg::core_mask_t   dbg_req_q;
  soc_event_pkg::evt_status_t  status_q, status_d;
  soc_event_pkg::evt_data_t    evt_data_q;
  logic [`SOC_DW-1:0]          boot_addr_q;
  logic [`SOC_DW-1:0]          rdata_d, rdata_q;
  logic [`SOC_DW-1:0]          wmask;
  logic                        r_valid_q, evt_valid_q;
  logic                        wr_en, rd_en, push_req, status_clr;

  // every request is granted at once
  assign per.gnt     = per.req;
  assign per.r_valid = r_valid_q;
  assign per.rdata   = rdata_q;

  assign reg_addr   = soc_event_pkg::reg_addr_e'(per.addr);
  assign wr_en      = per.req & per.we;
  assign rd_en      = per.req & ~per.we;
  assign push_req   = wr_en & per.be[0] & (reg_addr == soc_event_pkg::REG_EVT_PUSH);
  assign status_clr = rd_en & (reg_addr == soc_event_pkg::REG_EVT_STATUS);

  // byte enables expanded to a bit mask
  always_comb begin : be_mask
    for (int i = 0; i < `SOC_BE_W; i++) begin
      wmask[i*8 +: 8] = {8{per.be[i]}};
    end
  end

  always_comb begin : read_mux
    case (reg_addr)
      soc_event_pkg::REG_BOOT_ADDR:  rdata_d = boot_addr_q;
      soc_event_pkg::REG_CL_CTRL:    rdata_d = `SOC_DW'(cl_ctrl_q);
      soc_event_pkg::REG_DBG_REQ:    rdata_d = `SOC_DW'(dbg_req_q);
      soc_event_pkg::REG_EVT_PUSH:   rdata_d = `SOC_DW'(evt_ready_i);
      soc_event_pkg::REG_EVT_STATUS: rdata_d = `SOC_DW'(status_q);
      default:                       rdata_d = '0;
    endcase
  end

  // sticky events, a drop when the fifo is not ready
  always_comb begin : status_next
    status_d = status_clr ? '0 : status_q;
    status_d.dma_pe_evt = status_d.dma_pe_evt | dma_pe_evt_i;
    status_d.dma_pe_irq = status_d.dma_pe_irq | dma_pe_irq_i;
    status_d.pf_evt     = status_d.pf_evt | pf_evt_i;
    status_d.push_drop  = status_d.push_drop | (push_req & ~evt_ready_i) |
                          (evt_valid_q & ~evt_ready_i);
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin : ctrl_regs
    if (!s_soc_rstn) begin
      boot_addr_q <= `SOC_BOOT_ADDR_RST;
      cl_ctrl_q   <= '0;
      dbg_req_q   <= '0;
      status_q    <= '0;
      r_valid_q   <= 1'b0;
      evt_valid_q <= 1'b0;
    end else begin
      r_valid_q   <= per.req & per.gnt;
      evt_valid_q <= push_req & evt_ready_i;
      status_q    <= status_d;
      if (wr_en) begin
        case (reg_addr)
          soc_event_pkg::REG_BOOT_ADDR:
            boot_addr_q <= (boot_addr_q & ~wmask) | (per.wdata & wmask);
          soc_event_pkg::REG_CL_CTRL:
            if (per.be[0]) cl_ctrl_q <= soc_event_pkg::cl_ctrl_t'(per.wdata[2:0]);
          soc_event_pkg::REG_DBG_REQ:
            if (per.be[0]) dbg_req_q <= per.wdata[`SOC_NB_CORES-1:0];
          default: ;
        endcase
      end
    end
  end

  // read data and event payload
  always_ff @(posedge s_soc_clk) begin : payload_regs
    if (per.req) begin
      rdata_q <= rdata_d;
    end
    if (push_req & evt_ready_i) begin
      evt_data_q <= per.wdata[`SOC_EVNT_W-1:0];
    end
  end

  assign evt_valid_o = evt_valid_q;
  assign evt_data_o  = evt_data_q;
  assign cl_ctrl_o   = cl_ctrl_q;
  assign boot_addr_o = boot_addr_q;
  assign dbg_req_o   = dbg_req_q;

endmodule

/* source/apb_per_bridge.sv */
// ************************************************
// apb target to peripheral request/grant bridge
// one request per access phase
// ************************************************

`include "soc_event_defs.svh"

module apb_per_bridge (
  input  logic                   s_soc_clk,
  input  logic                   s_soc_rstn,
  input  logic [`SOC_APB_AW-1:0] paddr_i,
  input  logic [`SOC_DW-1:0]     pwdata_i,
  input  logic                   pwrite_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  output logic [`SOC_DW-1:0]     prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  per_bus_if.master              per
);

  soc_event_pkg::bridge_state_e state_q, state_d;
  logic access;

  assign access = psel_i & penable_i;

  // request fields follow the apb transfer directly
  assign per.we    = pwrite_i;
  assign per.addr  = paddr_i;
  assign per.wdata = pwdata_i;
  // apb3 carries no strobes so every access covers a full word
  assign per.be    = '1;

  always_comb begin : next_state
    state_d = state_q;
    per.req = 1'b0;
    case (state_q)
      soc_event_pkg::IDLE: begin
        if (access) begin
          per.req = 1'b1;
          if (per.gnt) begin
            state_d = soc_event_pkg::WAIT_RESP;
          end
        end
      end
      soc_event_pkg::WAIT_RESP: begin
        if (per.r_valid) begin
          state_d = soc_event_pkg::IDLE;
        end
      end
      default: state_d = soc_event_pkg::IDLE;
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin : state_reg
    if (!s_soc_rstn) begin
      state_q <= soc_event_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // response completes the access phase
  assign pready_o  = (state_q == soc_event_pkg::WAIT_RESP) & per.r_valid;
  assign prdata_o  = per.rdata;
  assign pslverr_o = 1'b0;

endmodule

/* cluster_events/event_dc_fifo.sv */
// ************************************************
// write side of the token-ring event fifo
// slots are read directly by the cluster
// ************************************************

`include "soc_event_defs.svh"

module event_dc_fifo (
  input  logic                                         s_soc_clk,
  input  logic                                         rstn_i,
  input  soc_event_pkg::evt_data_t                     data_i,
  input  logic                                         valid_i,
  output logic                                         ready_o,
  output logic [`SOC_EVT_FIFO_DEPTH-1:0]               write_token_o,
  input  logic [`SOC_EVT_FIFO_DEPTH-1:0]               read_pointer_i,
  output logic [`SOC_EVT_FIFO_DEPTH*`SOC_EVNT_W-1:0]   data_async_o
);

  localparam int DEPTH = `SOC_EVT_FIFO_DEPTH;

  soc_event_pkg::evt_data_t [DEPTH-1:0] slot_q;
  logic [DEPTH-1:0] wr_token_q, wr_token_d;
  logic [DEPTH-1:0] rp_meta_q, rp_sync_q;
  logic             ready_q;
  logic             push;

  // advance a one-hot token by one slot
  function automatic logic [DEPTH-1:0] rotate_token(input logic [DEPTH-1:0] tok);
    return {tok[DEPTH-2:0], tok[DEPTH-1]};
  endfunction

  assign push       = valid_i & ready_q;
  assign wr_token_d = push ? rotate_token(wr_token_q) : wr_token_q;

  // ************************************************
  // token, pointer synchronizer and ready
  // ************************************************

  always_ff @(posedge s_soc_clk or negedge rstn_i) begin : ring_ctrl
    if (!rstn_i) begin
      wr_token_q <= DEPTH'(1);
      rp_meta_q  <= DEPTH'(1);
      rp_sync_q  <= DEPTH'(1);
      ready_q    <= 1'b0;
    end else begin
      wr_token_q <= wr_token_d;
      rp_meta_q  <= read_pointer_i;
      rp_sync_q  <= rp_meta_q;
      // full keeps one slot free between token and pointer
      ready_q    <= (rotate_token(wr_token_d) != rp_sync_q);
    end
  end

  // slot storage, written at the token position
  always_ff @(posedge s_soc_clk) begin : slot_write
    for (int i = 0; i < DEPTH; i++) begin
      if (push && wr_token_q[i]) begin
        slot_q[i] <= data_i;
      end
    end
  end

  assign ready_o       = ready_q;
  assign write_token_o = wr_token_q;
  assign data_async_o  = slot_q;

endmodule

/* cluster_events/edge_rx.sv */
// ************************************************
// cluster event receiver
// level from the cluster to a one-cycle pulse
// ************************************************

module edge_rx (
  input  logic s_soc_clk,
  input  logic rstn_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       last_q;

  // two-flop synchronizer plus history flop
  always_ff @(posedge s_soc_clk or negedge rstn_i) begin : sync_regs
    if (!rstn_i) begin
      sync_q <= 2'b00;
      last_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      last_q <= sync_q[1];
    end
  end

  // rising edge of the synchronized level
  assign valid_o = sync_q[1] & ~last_q;

  // cluster sees its own level come back
  assign ack_o = sync_q[1];

endmodule

/* common/per_bus_if.sv */
// ************************************************
// peripheral request/grant bus
// ************************************************

`include "soc_event_defs.svh"

interface per_bus_if;

  // request side
  logic                   req;
  logic                   we;
  logic [`SOC_APB_AW-1:0] addr;
  logic [`SOC_DW-1:0]     wdata;
  logic [`SOC_BE_W-1:0]   be;

  // response side
  logic                   gnt;
  logic                   r_valid;
  logic [`SOC_DW-1:0]     rdata;

  modport master (
    output req, we, addr, wdata, be,
    input  gnt, r_valid, rdata
  );

  modport slave (
    input  req, we, addr, wdata, be,
    output gnt, r_valid, rdata
  );

endinterface

/* common/soc_event_pkg.sv */
// ************************************************
// shared types of the soc event domain
// ************************************************

`include "soc_event_defs.svh"

package soc_event_pkg;

  // control register map
  typedef enum logic [`SOC_APB_AW-1:0] {
    REG_BOOT_ADDR  = `SOC_REG_BOOT_ADDR,
    REG_CL_CTRL    = `SOC_REG_CL_CTRL,
    REG_DBG_REQ    = `SOC_REG_DBG_REQ,
    REG_EVT_PUSH   = `SOC_REG_EVT_PUSH,
    REG_EVT_STATUS = `SOC_REG_EVT_STATUS
  } reg_addr_e;

  typedef enum logic {
    IDLE,
    WAIT_RESP
  } bridge_state_e;

  typedef logic [`SOC_EVNT_W-1:0] evt_data_t;

  // irq sits in bit 0, fetch_en in bit 2
  typedef struct packed {
    logic fetch_en;
    logic rstn;
    logic irq;
  } cl_ctrl_t;

  typedef struct packed {
    logic dma_pe_evt;
    logic dma_pe_irq;
    logic pf_evt;
    logic push_drop;
  } evt_status_t;

  typedef logic [`SOC_NB_CORES-1:0] core_mask_t;

endpackage

/* common/soc_event_defs.svh */
// ************************************************
// soc event domain widths, depths and register map
// ************************************************

`ifndef SOC_EVENT_DEFS_SVH
`define SOC_EVENT_DEFS_SVH

// bus widths
`define SOC_APB_AW 32
`define SOC_DW 32
`define SOC_BE_W 4

// cluster side
`define SOC_NB_CORES 8
`define SOC_EVNT_W 8
`define SOC_EVT_FIFO_DEPTH 8

`define SOC_BOOT_ADDR_RST 32'h1C008080

// register byte offsets
`define SOC_REG_BOOT_ADDR 32'h0000_0000
`define SOC_REG_CL_CTRL 32'h0000_0004
`define SOC_REG_DBG_REQ 32'h0000_0008
`define SOC_REG_EVT_PUSH 32'h0000_000C
`define SOC_REG_EVT_STATUS 32'h0000_0010

`endif
